// ==== sim.f ====
+incdir+bench
source/mipsIsaPkg.sv
source/controlPkg.sv
source/aluDecoder.sv
source/instructionDecoder.sv
source/forwardUnit.sv
source/memoryMapDecoder.sv
source/controlUnit.sv
bench/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module controlUnitTb -o simv
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  exit 1
fi
echo "$output" | grep -q "^ALL CHECKS PASSED$" || exit 1
exit 0

// ==== bench/controlModel.svh ====
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// Expected ALU operation from opcode and funct
function automatic mipsIsaPkg::aluOpT modelAluOp(logic [31:0] ins);
  logic [5:0] op;
  logic [5:0] fn;
  op = ins[31:26];
  fn = ins[5:0];
  if (op == mipsIsaPkg::OpRtype) begin
    case (fn)
      mipsIsaPkg::FnSll, mipsIsaPkg::FnSllv: return mipsIsaPkg::AluSll;
      mipsIsaPkg::FnSrl, mipsIsaPkg::FnSrlv: return mipsIsaPkg::AluSrl;
      mipsIsaPkg::FnSra, mipsIsaPkg::FnSrav: return mipsIsaPkg::AluSra;
      mipsIsaPkg::FnSubu: return mipsIsaPkg::AluSub;
      mipsIsaPkg::FnAnd: return mipsIsaPkg::AluAnd;
      mipsIsaPkg::FnOr: return mipsIsaPkg::AluOr;
      mipsIsaPkg::FnXor: return mipsIsaPkg::AluXor;
      mipsIsaPkg::FnNor: return mipsIsaPkg::AluNor;
      mipsIsaPkg::FnSlt: return mipsIsaPkg::AluSlt;
      mipsIsaPkg::FnSltu: return mipsIsaPkg::AluSltu;
      default: return mipsIsaPkg::AluAdd;
    endcase
  end
  case (op)
    mipsIsaPkg::OpSlti, mipsIsaPkg::OpBlez, mipsIsaPkg::OpBgtz: return mipsIsaPkg::AluSlt;
    mipsIsaPkg::OpSltiu: return mipsIsaPkg::AluSltu;
    mipsIsaPkg::OpAndi: return mipsIsaPkg::AluAnd;
    mipsIsaPkg::OpOri: return mipsIsaPkg::AluOr;
    mipsIsaPkg::OpXori: return mipsIsaPkg::AluXor;
    mipsIsaPkg::OpLui: return mipsIsaPkg::AluLui;
    mipsIsaPkg::OpBeq, mipsIsaPkg::OpBne: return mipsIsaPkg::AluSub;
    default: return mipsIsaPkg::AluAdd;
  endcase
endfunction

function automatic controlPkg::decodeT modelDecode(logic [31:0] ins, logic br);
  controlPkg::decodeT d;
  logic [5:0] op;
  logic [5:0] fn;
  logic isR;
  op = ins[31:26];
  fn = ins[5:0];
  isR = op == mipsIsaPkg::OpRtype;
  d = '0;
  d.regWrite = (isR && fn != mipsIsaPkg::FnJr) ||
               (op >= mipsIsaPkg::OpAddiu && op <= mipsIsaPkg::OpLui) ||
               (op >= mipsIsaPkg::OpLb && op <= mipsIsaPkg::OpLhu) || op == mipsIsaPkg::OpJal;
  if (isR) d.regDst = controlPkg::RegDstRd;
  else if (op == mipsIsaPkg::OpJal) d.regDst = controlPkg::RegDstRa;
  else d.regDst = controlPkg::RegDstRt;
  d.sextImm = !(op >= mipsIsaPkg::OpAndi && op <= mipsIsaPkg::OpLui);
  d.memRead = op >= mipsIsaPkg::OpLb && op <= mipsIsaPkg::OpLhu;
  d.memWrite = op >= mipsIsaPkg::OpSb && op <= mipsIsaPkg::OpSw;
  case (op)
    mipsIsaPkg::OpLb, mipsIsaPkg::OpLbu, mipsIsaPkg::OpSb: d.accessSize = controlPkg::SizeByte;
    mipsIsaPkg::OpLh, mipsIsaPkg::OpLhu, mipsIsaPkg::OpSh: d.accessSize = controlPkg::SizeHalf;
    default: d.accessSize = controlPkg::SizeWord;
  endcase
  if (br) d.pcSel = controlPkg::PcSelBranch;
  else if (op == mipsIsaPkg::OpJ || op == mipsIsaPkg::OpJal) d.pcSel = controlPkg::PcSelJump;
  else if (isR && (fn == mipsIsaPkg::FnJr || fn == mipsIsaPkg::FnJalr)) begin
    d.pcSel = controlPkg::PcSelReg;
  end else d.pcSel = controlPkg::PcSelNext;
  return d;
endfunction

// Register that the instruction writes, 0 when none
function automatic logic [4:0] modelDest(logic [31:0] ins);
  logic [5:0] op;
  op = ins[31:26];
  if (op == mipsIsaPkg::OpRtype && ins[5:0] != mipsIsaPkg::FnJr) return ins[15:11];
  if (op >= mipsIsaPkg::OpAddiu && op <= mipsIsaPkg::OpLui) return ins[20:16];
  if (op >= mipsIsaPkg::OpLb && op <= mipsIsaPkg::OpLhu) return ins[20:16];
  return 5'd0;
endfunction

function automatic controlPkg::fwdCtrlT modelFwd(logic [31:0] ins, logic [4:0] prev);
  controlPkg::fwdCtrlT f;
  logic [5:0] op;
  logic [5:0] fn;
  logic isR;
  logic mRs;
  logic mRt;
  op = ins[31:26];
  fn = ins[5:0];
  isR = op == mipsIsaPkg::OpRtype;
  mRs = prev != 5'd0 && ins[25:21] == prev;
  mRt = prev != 5'd0 && ins[20:16] == prev;
  f.aluSelA = mRs ? controlPkg::OperandFwd : controlPkg::OperandReg;
  f.aluSelB = mRt ? controlPkg::OperandFwd : controlPkg::OperandReg;
  f.dinSel = 1'b0;
  f.jrSel = isR && (fn == mipsIsaPkg::FnJr || fn == mipsIsaPkg::FnJalr) && mRs;
  if (op == mipsIsaPkg::OpJal || (isR && fn == mipsIsaPkg::FnJalr)) begin
    f.aluSelA = controlPkg::OperandPc;
    f.aluSelB = controlPkg::OperandPc;
  end else if (isR && fn <= mipsIsaPkg::FnSra) begin
    f.aluSelA = controlPkg::OperandAux;
  end else if (op >= mipsIsaPkg::OpAddiu && op <= mipsIsaPkg::OpLui ||
               op >= mipsIsaPkg::OpLb && op <= mipsIsaPkg::OpSw) begin
    f.aluSelB = controlPkg::OperandAux;
    f.dinSel = op >= mipsIsaPkg::OpSb && mRt;
  end
  return f;
endfunction

function automatic controlPkg::memCtrlT modelMem(controlPkg::decodeT d, logic [31:0] addr,
                                                 logic [31:0] pcV, logic [1:0] off);
  controlPkg::memCtrlT m;
  logic [3:0] region;
  logic [3:0] lanes;
  logic weD;
  logic weI;
  region = addr[31:28];
  // Region 3 reaches both memories
  weD = d.memWrite && (region == 4'h1 || region == 4'h3);
  weI = d.memWrite && (region == 4'h2 || region == 4'h3) && pcV[31:28] == 4'h4;
  case (d.accessSize)
    controlPkg::SizeByte: lanes = 4'b1000 >> off;
    controlPkg::SizeHalf: lanes = off[1] ? 4'b0011 : 4'b1100;
    default: lanes = 4'b1111;
  endcase
  m = '0;
  m.imByteSel = weI ? lanes : 4'b0000;
  m.dmByteSel = weD ? lanes : 4'b0000;
  m.iCacheSel = weI;
  m.rdSel = controlPkg::RdSelAlu;
  if (d.memRead) begin
    if (region == 4'h1) begin
      m.reDcache = 1'b1;
      m.rdSel = controlPkg::RdSelDcache;
    end
    case (addr)
      controlPkg::UartRxReadyAddr: begin
        m.uartSel = controlPkg::UartSelRxReady;
        m.rdSel = controlPkg::RdSelIo;
      end
      controlPkg::UartTxReadyAddr: begin
        m.uartSel = controlPkg::UartSelTxReady;
        m.rdSel = controlPkg::RdSelIo;
      end
      controlPkg::UartRxDataAddr: begin
        m.uartSel = controlPkg::UartSelRxData;
        m.reUart = 1'b1;
        m.rdSel = controlPkg::RdSelIo;
      end
      controlPkg::CycleCountAddr: m.rdSel = controlPkg::RdSelCounter;
      controlPkg::InstrCountAddr: begin
        m.ctSel = 1'b1;
        m.rdSel = controlPkg::RdSelCounter;
      end
      default: begin
        if (region == 4'h4) begin
          m.uartSel = controlPkg::UartSelBios;
          m.rdSel = controlPkg::RdSelIo;
        end
      end
    endcase
  end
  m.weUart = d.memWrite && addr == controlPkg::UartTxDataAddr;
  m.ctReset = d.memWrite && addr == controlPkg::CountResetAddr;
  return m;
endfunction

// Access that goes through a cache and so stalls once
function automatic logic modelNeedsStall(controlPkg::decodeT d, logic [31:0] addr,
                                         logic [31:0] pcV);
  logic [3:0] region;
  region = addr[31:28];
  return (d.memRead && region == 4'h1) ||
         (d.memWrite && (region == 4'h1 || region == 4'h3)) ||
         (d.memWrite && (region == 4'h2 || region == 4'h3) && pcV[31:28] == 4'h4);
endfunction

`endif

// ==== bench/controlUnitTb.sv ====
module controlUnitTb;

  `include "controlModel.svh"

  // Cycles of all tests together, reset included
  localparam int TotalCycles = 110;
  localparam logic [31:0] UserPc = 32'h0040_0000;
  localparam logic [31:0] BiosPc = 32'h4000_0100;

  logic clk;
  logic rstN;
  logic [31:0] instruction;
  logic [31:0] pc;
  logic [31:0] address;
  logic [1:0] offset;
  logic branch;
  mipsIsaPkg::aluOpT aluOp;
  controlPkg::decodeT decode;
  controlPkg::fwdCtrlT fwd;
  controlPkg::memCtrlT mem;
  logic controlStall;

  int errors = 0;
  int checks = 0;
  int errStart = 0;
  int testNum = 0;
  logic [31:0] rngState = 32'd10587;
  logic [4:0] modelPrev = 5'd0;
  logic modelOldStall = 1'b0;

  mipsIsaPkg::functT functs[8] = '{mipsIsaPkg::FnSll, mipsIsaPkg::FnSrlv, mipsIsaPkg::FnSra,
    mipsIsaPkg::FnAddu, mipsIsaPkg::FnSubu, mipsIsaPkg::FnAnd, mipsIsaPkg::FnNor,
    mipsIsaPkg::FnSltu};
  mipsIsaPkg::opcodeT immOps[8] = '{mipsIsaPkg::OpAddiu, mipsIsaPkg::OpSlti,
    mipsIsaPkg::OpSltiu, mipsIsaPkg::OpAndi, mipsIsaPkg::OpOri, mipsIsaPkg::OpXori,
    mipsIsaPkg::OpLui, mipsIsaPkg::OpAddiu};
  mipsIsaPkg::opcodeT memOps[8] = '{mipsIsaPkg::OpLb, mipsIsaPkg::OpLh, mipsIsaPkg::OpLw,
    mipsIsaPkg::OpLbu, mipsIsaPkg::OpLhu, mipsIsaPkg::OpSb, mipsIsaPkg::OpSh,
    mipsIsaPkg::OpSw};

  controlUnit controlUnit_inst (
    .clk(clk),
    .rstN(rstN),
    .instruction(instruction),
    .pc(pc),
    .address(address),
    .offset(offset),
    .branch(branch),
    .aluOp(aluOp),
    .decode(decode),
    .fwd(fwd),
    .mem(mem),
    .controlStall(controlStall)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic logic [31:0] rInstr(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                         logic [5:0] fn);
    return {6'h00, rs, rt, rd, 5'd3, fn};
  endfunction

  function automatic logic [31:0] iInstr(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                         logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic checkValue(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic finishTest(string name);
    testNum++;
    $display("Test %0d %s done with %0d errors", testNum, name, errors - errStart);
    errStart = errors;
  endtask

  // Drive one instruction, check before the next edge, then advance the model
  task automatic step(logic [31:0] ins, logic [31:0] pcV, logic [31:0] addr, logic br);
    controlPkg::decodeT d;
    logic expStall;
    instruction = ins;
    pc = pcV;
    address = addr;
    offset = addr[1:0];
    branch = br;
    #16;
    d = modelDecode(ins, br);
    expStall = modelNeedsStall(d, addr, pcV) && !modelOldStall;
    checkValue("aluOp", 32'(modelAluOp(ins)), 32'(aluOp));
    checkValue("decode", 32'(d), 32'(decode));
    checkValue("fwd", 32'(modelFwd(ins, modelPrev)), 32'(fwd));
    checkValue("mem", 32'(modelMem(d, addr, pcV, addr[1:0])), 32'(mem));
    checkValue("controlStall", 32'(expStall), 32'(controlStall));
    @(posedge clk);
    if (!expStall) modelPrev = modelDest(ins);
    modelOldStall = expStall;
    #2;
  endtask

  initial begin
    #(2 * TotalCycles * 20);
    $display("Timeout: the run went past its cycle budget");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] ins;
    clk = 1'b0;
    rstN = 1'b0;
    instruction = '0;
    pc = '0;
    address = '0;
    offset = '0;
    branch = 1'b0;

    // Cache stores and loads with a taken branch still give all zeros
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      #2;
      if (i[0]) begin
        instruction = iInstr(mipsIsaPkg::OpLw, 5'd1, 5'd3, 16'h0);
        address = 32'h1000_0000;
      end else begin
        instruction = iInstr(mipsIsaPkg::OpSw, 5'd1, 5'd2, 16'h0);
        address = 32'h3000_0000;
      end
      pc = BiosPc;
      branch = 1'b1;
      #16;
      checkValue("decode", 32'd0, 32'(decode));
      checkValue("fwd", 32'd0, 32'(fwd));
      checkValue("mem", 32'd0, 32'(mem));
      checkValue("controlStall", 32'd0, 32'(controlStall));
    end
    @(posedge clk);
    #2;
    rstN = 1'b1;
    // Source r3 matches the load left on the inputs during reset
    step(rInstr(5'd3, 5'd4, 5'd5, mipsIsaPkg::FnAddu), UserPc, 32'h0, 1'b0);
    finishTest("reset");

    for (int i = 0; i < 40; i++) begin
      r = nextRandom();
      case (r[2:0])
        3'd0, 3'd1, 3'd2: ins = rInstr(r[7:3], r[12:8], r[17:13], functs[r[20:18]]);
        3'd3, 3'd4: ins = iInstr(immOps[r[20:18]], r[7:3], r[12:8], r[31:16]);
        default: ins = iInstr(memOps[r[20:18]], r[7:3], r[12:8], r[31:16]);
      endcase
      step(ins, UserPc, nextRandom(), 1'b0);
    end
    finishTest("random decode");

    step(iInstr(mipsIsaPkg::OpBeq, 5'd1, 5'd2, 16'h10), UserPc, 32'h0, 1'b1);
    step(iInstr(mipsIsaPkg::OpBne, 5'd1, 5'd2, 16'h10), UserPc, 32'h0, 1'b0);
    step({mipsIsaPkg::OpJ, 26'h100}, UserPc, 32'h0, 1'b0);
    step({mipsIsaPkg::OpJal, 26'h200}, UserPc, 32'h0, 1'b0);
    step({mipsIsaPkg::OpJ, 26'h300}, UserPc, 32'h0, 1'b1);
    step(rInstr(5'd9, 5'd0, 5'd0, mipsIsaPkg::FnJr), UserPc, 32'h0, 1'b0);
    step(rInstr(5'd9, 5'd0, 5'd31, mipsIsaPkg::FnJalr), UserPc, 32'h0, 1'b0);
    finishTest("next PC");

    step(rInstr(5'd1, 5'd2, 5'd9, mipsIsaPkg::FnAddu), UserPc, 32'h0, 1'b0);
    step(rInstr(5'd9, 5'd3, 5'd10, mipsIsaPkg::FnSubu), UserPc, 32'h0, 1'b0);
    step(iInstr(mipsIsaPkg::OpOri, 5'd1, 5'd4, 16'h5), UserPc, 32'h0, 1'b0);
    step(iInstr(mipsIsaPkg::OpSw, 5'd4, 5'd4, 16'h0), UserPc, 32'h0, 1'b0);
    step(rInstr(5'd1, 5'd2, 5'd0, mipsIsaPkg::FnAddu), UserPc, 32'h0, 1'b0);
    step(rInstr(5'd0, 5'd0, 5'd11, mipsIsaPkg::FnAddu), UserPc, 32'h0, 1'b0);
    step(rInstr(5'd1, 5'd2, 5'd6, mipsIsaPkg::FnAnd), UserPc, 32'h0, 1'b0);
    step(rInstr(5'd6, 5'd0, 5'd0, mipsIsaPkg::FnJr), UserPc, 32'h0, 1'b0);
    step(iInstr(mipsIsaPkg::OpLw, 5'd1, 5'd12, 16'h0), UserPc, 32'h0, 1'b0);
    step(rInstr(5'd12, 5'd0, 5'd31, mipsIsaPkg::FnJalr), UserPc, 32'h0, 1'b0);
    step(rInstr(5'd1, 5'd2, 5'd2, mipsIsaPkg::FnSll), UserPc, 32'h0, 1'b0);
    step(rInstr(5'd3, 5'd2, 5'd4, mipsIsaPkg::FnSll), UserPc, 32'h0, 1'b0);
    finishTest("forwarding");

    step(iInstr(mipsIsaPkg::OpLw, 5'd1, 5'd2, 16'h0), UserPc, controlPkg::UartRxReadyAddr, 1'b0);
    step(iInstr(mipsIsaPkg::OpLw, 5'd1, 5'd2, 16'h0), UserPc, controlPkg::UartTxReadyAddr, 1'b0);
    step(iInstr(mipsIsaPkg::OpLw, 5'd1, 5'd2, 16'h0), UserPc, controlPkg::UartRxDataAddr, 1'b0);
    step(iInstr(mipsIsaPkg::OpLw, 5'd1, 5'd2, 16'h0), UserPc, controlPkg::CycleCountAddr, 1'b0);
    step(iInstr(mipsIsaPkg::OpLw, 5'd1, 5'd2, 16'h0), UserPc, controlPkg::InstrCountAddr, 1'b0);
    step(iInstr(mipsIsaPkg::OpLw, 5'd1, 5'd2, 16'h0), UserPc, 32'h4000_0010, 1'b0);
    step(iInstr(mipsIsaPkg::OpLw, 5'd1, 5'd2, 16'h0), UserPc, 32'h0000_0100, 1'b0);
    step(iInstr(mipsIsaPkg::OpSw, 5'd1, 5'd2, 16'h0), UserPc, controlPkg::UartTxDataAddr, 1'b0);
    step(iInstr(mipsIsaPkg::OpSw, 5'd1, 5'd2, 16'h0), UserPc, controlPkg::CountResetAddr, 1'b0);
    // Region 3 from BIOS code writes both memories
    for (int off = 0; off < 4; off++) begin
      step(iInstr(mipsIsaPkg::OpSb, 5'd1, 5'd2, 16'h0), BiosPc, 32'h3000_0080 + off, 1'b0);
      step(iInstr(mipsIsaPkg::OpSh, 5'd1, 5'd2, 16'h0), BiosPc, 32'h3000_0080 + off, 1'b0);
      step(iInstr(mipsIsaPkg::OpSw, 5'd1, 5'd2, 16'h0), BiosPc, 32'h3000_0080 + off, 1'b0);
    end
    step(iInstr(mipsIsaPkg::OpSw, 5'd1, 5'd2, 16'h0), UserPc, 32'h2000_0040, 1'b0);
    step(iInstr(mipsIsaPkg::OpSh, 5'd1, 5'd2, 16'h0), BiosPc, 32'h2000_0042, 1'b0);
    step(iInstr(mipsIsaPkg::OpSb, 5'd1, 5'd2, 16'h0), UserPc, 32'h1000_0041, 1'b0);
    finishTest("memory map");

    // Held load keeps the older destination through its stall cycle
    step(rInstr(5'd1, 5'd2, 5'd7, mipsIsaPkg::FnAddu), UserPc, 32'h0, 1'b0);
    step(iInstr(mipsIsaPkg::OpLw, 5'd7, 5'd5, 16'h40), UserPc, 32'h1000_0040, 1'b0);
    step(iInstr(mipsIsaPkg::OpLw, 5'd7, 5'd5, 16'h40), UserPc, 32'h1000_0040, 1'b0);
    step(rInstr(5'd5, 5'd5, 5'd8, mipsIsaPkg::FnAddu), UserPc, 32'h0, 1'b0);
    finishTest("stall");

    $display("Checks run: %0d, failed: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== source/controlUnit.sv ====
module controlUnit (
  input  logic clk,
  input  logic rstN,
  input  mipsIsaPkg::instrT instruction,
  input  controlPkg::addrT pc,
  input  controlPkg::addrT address,
  input  logic [1:0] offset,
  input  logic branch,
  output mipsIsaPkg::aluOpT aluOp,
  output controlPkg::decodeT decode,
  output controlPkg::fwdCtrlT fwd,
  output controlPkg::memCtrlT mem,
  output logic controlStall
);

  mipsIsaPkg::rTypeT fields;

  assign fields = instruction;

  aluDecoder aluDecoder_inst (
    .opcode(fields.opcode),
    .funct(fields.funct),
    .aluOp(aluOp)
  );

  instructionDecoder instructionDecoder_inst (
    .instruction(instruction),
    .branch(branch),
    .rstN(rstN),
    .decode(decode)
  );

  // Stall freezes the forwarding history
  forwardUnit forwardUnit_inst (
    .clk(clk),
    .rstN(rstN),
    .instruction(instruction),
    .hold(controlStall),
    .fwd(fwd)
  );

  memoryMapDecoder memoryMapDecoder_inst (
    .clk(clk),
    .rstN(rstN),
    .decode(decode),
    .address(address),
    .pc(pc),
    .offset(offset),
    .mem(mem),
    .controlStall(controlStall)
  );

endmodule

// ==== source/memoryMapDecoder.sv ====
module memoryMapDecoder (
  input  logic clk,
  input  logic rstN,
  input  controlPkg::decodeT decode,
  input  controlPkg::addrT address,
  input  controlPkg::addrT pc,
  input  logic [1:0] offset,
  output controlPkg::memCtrlT mem,
  output logic controlStall
);

  logic [3:0] region;
  logic dataRegion;
  logic instrRegion;
  logic weDcache;
  logic weImem;
  logic reDcache;
  logic oldStall;
  controlPkg::byteMaskT lanes;
  controlPkg::memCtrlT memNext;

  assign region = address[31:28];
  // Region 3 aliases both memories
  assign dataRegion = (region == controlPkg::RegionData) ||
                      (region == (controlPkg::RegionData | controlPkg::RegionInstr));
  assign instrRegion = (region == controlPkg::RegionInstr) ||
                       (region == (controlPkg::RegionData | controlPkg::RegionInstr));

  assign weDcache = decode.memWrite && dataRegion;
  // Instruction memory is writable only from BIOS code
  assign weImem = decode.memWrite && instrRegion && (pc[31:28] == controlPkg::RegionBios);
  assign reDcache = decode.memRead && (region == controlPkg::RegionData);

  always_comb begin
    case (decode.accessSize)
      controlPkg::SizeByte: lanes = 4'b1000 >> offset;
      controlPkg::SizeHalf: lanes = offset[1] ? 4'b0011 : 4'b1100;
      default: lanes = 4'b1111;
    endcase
  end

  always_comb begin
    memNext = '0;
    memNext.imByteSel = weImem ? lanes : '0;
    memNext.dmByteSel = weDcache ? lanes : '0;
    memNext.iCacheSel = weImem;
    memNext.reDcache = reDcache;
    memNext.rdSel = controlPkg::RdSelAlu;

    if (reDcache) begin
      memNext.rdSel = controlPkg::RdSelDcache;
    end

    // UART and BIOS reads go through the I/O path
    if (decode.memRead) begin
      if (address == controlPkg::UartRxReadyAddr) begin
        memNext.uartSel = controlPkg::UartSelRxReady;
        memNext.rdSel = controlPkg::RdSelIo;
      end else if (address == controlPkg::UartTxReadyAddr) begin
        memNext.uartSel = controlPkg::UartSelTxReady;
        memNext.rdSel = controlPkg::RdSelIo;
      end else if (address == controlPkg::UartRxDataAddr) begin
        memNext.uartSel = controlPkg::UartSelRxData;
        memNext.reUart = 1'b1;
        memNext.rdSel = controlPkg::RdSelIo;
      end else if (address == controlPkg::CycleCountAddr) begin
        memNext.ctSel = 1'b0;
        memNext.rdSel = controlPkg::RdSelCounter;
      end else if (address == controlPkg::InstrCountAddr) begin
        memNext.ctSel = 1'b1;
        memNext.rdSel = controlPkg::RdSelCounter;
      end else if (region == controlPkg::RegionBios) begin
        memNext.uartSel = controlPkg::UartSelBios;
        memNext.rdSel = controlPkg::RdSelIo;
      end
    end

    memNext.weUart = decode.memWrite && (address == controlPkg::UartTxDataAddr);
    memNext.ctReset = decode.memWrite && (address == controlPkg::CountResetAddr);
  end

  assign mem = rstN ? memNext : '0;

  // One stall cycle per cache access
  assign controlStall = (reDcache || weDcache || weImem) && !oldStall;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      oldStall <= 1'b0;
    end else begin
      oldStall <= controlStall;
    end
  end

endmodule

// ==== source/forwardUnit.sv ====
module forwardUnit (
  input  logic clk,
  input  logic rstN,
  input  mipsIsaPkg::instrT instruction,
  input  logic hold,
  output controlPkg::fwdCtrlT fwd
);

  mipsIsaPkg::rTypeT fields;
  mipsIsaPkg::regAddrT prevDest;
  mipsIsaPkg::regAddrT nextDest;
  controlPkg::fwdCtrlT fwdNext;
  logic isRtype;
  logic isShift;
  logic isLink;
  logic isJumpReg;
  logic matchRs;
  logic matchRt;

  assign fields = instruction;
  assign isRtype = fields.opcode == mipsIsaPkg::OpRtype;
  assign isShift = isRtype && (fields.funct >= mipsIsaPkg::FnSll) &&
                   (fields.funct <= mipsIsaPkg::FnSra);
  assign isLink = (fields.opcode == mipsIsaPkg::OpJal) ||
                  (isRtype && (fields.funct == mipsIsaPkg::FnJalr));
  assign isJumpReg = isRtype &&
                     ((fields.funct == mipsIsaPkg::FnJr) ||
                      (fields.funct == mipsIsaPkg::FnJalr));

  // Register written by the instruction now in execute
  always_comb begin
    if (isRtype && (fields.funct != mipsIsaPkg::FnJr)) begin
      nextDest = fields.rd;
    end else if (mipsIsaPkg::isImmAlu(fields.opcode) || mipsIsaPkg::isLoad(fields.opcode)) begin
      nextDest = fields.rt;
    end else begin
      nextDest = '0;
    end
  end

  // A stall keeps the older destination in place
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      prevDest <= '0;
    end else if (!hold) begin
      prevDest <= nextDest;
    end
  end

  // Register 0 never forwards
  assign matchRs = (prevDest != '0) && (fields.rs == prevDest);
  assign matchRt = (prevDest != '0) && (fields.rt == prevDest);

  always_comb begin
    fwdNext.aluSelA = matchRs ? controlPkg::OperandFwd : controlPkg::OperandReg;
    fwdNext.aluSelB = matchRt ? controlPkg::OperandFwd : controlPkg::OperandReg;
    fwdNext.dinSel = 1'b0;
    fwdNext.jrSel = isJumpReg && matchRs;

    if (isLink) begin
      // Link address is computed from the PC
      fwdNext.aluSelA = controlPkg::OperandPc;
      fwdNext.aluSelB = controlPkg::OperandPc;
    end else if (isShift) begin
      fwdNext.aluSelA = controlPkg::OperandAux;
    end else if (mipsIsaPkg::isImmAlu(fields.opcode) || mipsIsaPkg::isLoad(fields.opcode) ||
                 mipsIsaPkg::isStore(fields.opcode)) begin
      fwdNext.aluSelB = controlPkg::OperandAux;
      // Store data comes from rt
      fwdNext.dinSel = mipsIsaPkg::isStore(fields.opcode) && matchRt;
    end
  end

  assign fwd = rstN ? fwdNext : '0;

endmodule

// ==== source/instructionDecoder.sv ====
module instructionDecoder (
  input  mipsIsaPkg::instrT instruction,
  input  logic branch,
  input  logic rstN,
  output controlPkg::decodeT decode
);

  mipsIsaPkg::rTypeT fields;
  controlPkg::decodeT decodeNext;
  logic isRtype;
  logic isJumpReg;

  assign fields = instruction;
  assign isRtype = fields.opcode == mipsIsaPkg::OpRtype;
  assign isJumpReg = isRtype &&
                     ((fields.funct == mipsIsaPkg::FnJr) ||
                      (fields.funct == mipsIsaPkg::FnJalr));

  always_comb begin
    decodeNext = '0;

    // Writeback
    decodeNext.regWrite = (isRtype && (fields.funct != mipsIsaPkg::FnJr)) ||
                          mipsIsaPkg::isImmAlu(fields.opcode) ||
                          mipsIsaPkg::isLoad(fields.opcode) ||
                          (fields.opcode == mipsIsaPkg::OpJal);
    if (isRtype) begin
      decodeNext.regDst = controlPkg::RegDstRd;
    end else if (fields.opcode == mipsIsaPkg::OpJal) begin
      decodeNext.regDst = controlPkg::RegDstRa;
    end else begin
      decodeNext.regDst = controlPkg::RegDstRt;
    end

    // Logical immediates and LUI are zero extended
    decodeNext.sextImm = !((fields.opcode >= mipsIsaPkg::OpAndi) &&
                           (fields.opcode <= mipsIsaPkg::OpLui));

    decodeNext.memRead = mipsIsaPkg::isLoad(fields.opcode);
    decodeNext.memWrite = mipsIsaPkg::isStore(fields.opcode);
    case (fields.opcode)
      mipsIsaPkg::OpLb, mipsIsaPkg::OpLbu, mipsIsaPkg::OpSb: begin
        decodeNext.accessSize = controlPkg::SizeByte;
      end
      mipsIsaPkg::OpLh, mipsIsaPkg::OpLhu, mipsIsaPkg::OpSh: begin
        decodeNext.accessSize = controlPkg::SizeHalf;
      end
      default: decodeNext.accessSize = controlPkg::SizeWord;
    endcase

    // Next PC, a taken branch wins
    if (branch) begin
      decodeNext.pcSel = controlPkg::PcSelBranch;
    end else if ((fields.opcode == mipsIsaPkg::OpJ) ||
                 (fields.opcode == mipsIsaPkg::OpJal)) begin
      decodeNext.pcSel = controlPkg::PcSelJump;
    end else if (isJumpReg) begin
      decodeNext.pcSel = controlPkg::PcSelReg;
    end else begin
      decodeNext.pcSel = controlPkg::PcSelNext;
    end
  end

  assign decode = rstN ? decodeNext : '0;

endmodule

// ==== source/aluDecoder.sv ====
module aluDecoder (
  input  mipsIsaPkg::opcodeT opcode,
  input  mipsIsaPkg::functT funct,
  output mipsIsaPkg::aluOpT aluOp
);

  always_comb begin
    case (opcode)
      mipsIsaPkg::OpRtype: begin
        case (funct)
          mipsIsaPkg::FnSll, mipsIsaPkg::FnSllv: aluOp = mipsIsaPkg::AluSll;
          mipsIsaPkg::FnSrl, mipsIsaPkg::FnSrlv: aluOp = mipsIsaPkg::AluSrl;
          mipsIsaPkg::FnSra, mipsIsaPkg::FnSrav: aluOp = mipsIsaPkg::AluSra;
          mipsIsaPkg::FnSubu: aluOp = mipsIsaPkg::AluSub;
          mipsIsaPkg::FnAnd: aluOp = mipsIsaPkg::AluAnd;
          mipsIsaPkg::FnOr: aluOp = mipsIsaPkg::AluOr;
          mipsIsaPkg::FnXor: aluOp = mipsIsaPkg::AluXor;
          mipsIsaPkg::FnNor: aluOp = mipsIsaPkg::AluNor;
          mipsIsaPkg::FnSlt: aluOp = mipsIsaPkg::AluSlt;
          mipsIsaPkg::FnSltu: aluOp = mipsIsaPkg::AluSltu;
          // ADDU, JR and JALR
          default: aluOp = mipsIsaPkg::AluAdd;
        endcase
      end
      mipsIsaPkg::OpSlti: aluOp = mipsIsaPkg::AluSlt;
      mipsIsaPkg::OpSltiu: aluOp = mipsIsaPkg::AluSltu;
      mipsIsaPkg::OpAndi: aluOp = mipsIsaPkg::AluAnd;
      mipsIsaPkg::OpOri: aluOp = mipsIsaPkg::AluOr;
      mipsIsaPkg::OpXori: aluOp = mipsIsaPkg::AluXor;
      mipsIsaPkg::OpLui: aluOp = mipsIsaPkg::AluLui;
      mipsIsaPkg::OpBeq, mipsIsaPkg::OpBne: aluOp = mipsIsaPkg::AluSub;
      mipsIsaPkg::OpBlez, mipsIsaPkg::OpBgtz: aluOp = mipsIsaPkg::AluSlt;
      // ADDIU, loads, stores and jumps compute a sum
      default: aluOp = mipsIsaPkg::AluAdd;
    endcase
  end

endmodule

// ==== source/controlPkg.sv ====
package controlPkg;

  typedef logic [31:0] addrT;
  typedef logic [3:0] byteMaskT;
  typedef logic [1:0] selT;
  typedef logic [1:0] accessSizeT;

  localparam selT PcSelNext = 2'd0;
  localparam selT PcSelBranch = 2'd1;
  localparam selT PcSelReg = 2'd2;
  localparam selT PcSelJump = 2'd3;

  localparam selT RegDstRt = 2'd0;
  localparam selT RegDstRd = 2'd1;
  localparam selT RegDstRa = 2'd2;

  // Writeback source
  localparam selT RdSelIo = 2'd0;
  localparam selT RdSelAlu = 2'd1;
  localparam selT RdSelDcache = 2'd2;
  localparam selT RdSelCounter = 2'd3;

  localparam selT UartSelRxData = 2'd0;
  localparam selT UartSelRxReady = 2'd1;
  localparam selT UartSelTxReady = 2'd2;
  localparam selT UartSelBios = 2'd3;

  // Aux is shamt on operand A, the immediate on operand B
  localparam selT OperandPc = 2'd0;
  localparam selT OperandReg = 2'd1;
  localparam selT OperandFwd = 2'd2;
  localparam selT OperandAux = 2'd3;

  localparam accessSizeT SizeByte = 2'd0;
  localparam accessSizeT SizeHalf = 2'd1;
  localparam accessSizeT SizeWord = 2'd2;

  // Address[31:28] regions
  localparam logic [3:0] RegionData = 4'h1;
  localparam logic [3:0] RegionInstr = 4'h2;
  localparam logic [3:0] RegionBios = 4'h4;

  localparam addrT UartRxReadyAddr = 32'h8000_0000;
  localparam addrT UartTxReadyAddr = 32'h8000_0004;
  localparam addrT UartTxDataAddr = 32'h8000_0008;
  localparam addrT UartRxDataAddr = 32'h8000_000C;
  localparam addrT CycleCountAddr = 32'h8000_0010;
  localparam addrT InstrCountAddr = 32'h8000_0014;
  localparam addrT CountResetAddr = 32'h8000_0018;

  typedef struct packed {
    logic regWrite;
    selT regDst;
    logic memRead;
    logic memWrite;
    accessSizeT accessSize;
    logic sextImm;
    selT pcSel;
  } decodeT;

  typedef struct packed {
    selT aluSelA;
    selT aluSelB;
    logic dinSel;
    logic jrSel;
  } fwdCtrlT;

  typedef struct packed {
    byteMaskT imByteSel;
    byteMaskT dmByteSel;
    logic iCacheSel;
    logic reDcache;
    logic reUart;
    logic weUart;
    selT uartSel;
    logic ctSel;
    logic ctReset;
    selT rdSel;
  } memCtrlT;

endpackage

// ==== source/mipsIsaPkg.sv ====
package mipsIsaPkg;

  typedef logic [5:0] opcodeT;
  typedef logic [5:0] functT;
  typedef logic [4:0] regAddrT;
  typedef logic [3:0] aluOpT;
  typedef logic [31:0] instrT;

  // R-type layout, also covers the rs/rt fields of I-type words
  typedef struct packed {
    opcodeT opcode;
    regAddrT rs;
    regAddrT rt;
    regAddrT rd;
    logic [4:0] shamt;
    functT funct;
  } rTypeT;

  localparam opcodeT OpRtype = 6'h00;
  localparam opcodeT OpJ = 6'h02;
  localparam opcodeT OpJal = 6'h03;
  localparam opcodeT OpBeq = 6'h04;
  localparam opcodeT OpBne = 6'h05;
  localparam opcodeT OpBlez = 6'h06;
  localparam opcodeT OpBgtz = 6'h07;
  localparam opcodeT OpAddiu = 6'h09;
  localparam opcodeT OpSlti = 6'h0A;
  localparam opcodeT OpSltiu = 6'h0B;
  localparam opcodeT OpAndi = 6'h0C;
  localparam opcodeT OpOri = 6'h0D;
  localparam opcodeT OpXori = 6'h0E;
  localparam opcodeT OpLui = 6'h0F;
  localparam opcodeT OpLb = 6'h20;
  localparam opcodeT OpLh = 6'h21;
  localparam opcodeT OpLw = 6'h23;
  localparam opcodeT OpLbu = 6'h24;
  localparam opcodeT OpLhu = 6'h25;
  localparam opcodeT OpSb = 6'h28;
  localparam opcodeT OpSh = 6'h29;
  localparam opcodeT OpSw = 6'h2B;

  localparam functT FnSll = 6'h00;
  localparam functT FnSrl = 6'h02;
  localparam functT FnSra = 6'h03;
  localparam functT FnSllv = 6'h04;
  localparam functT FnSrlv = 6'h06;
  localparam functT FnSrav = 6'h07;
  localparam functT FnJr = 6'h08;
  localparam functT FnJalr = 6'h09;
  localparam functT FnAddu = 6'h21;
  localparam functT FnSubu = 6'h23;
  localparam functT FnAnd = 6'h24;
  localparam functT FnOr = 6'h25;
  localparam functT FnXor = 6'h26;
  localparam functT FnNor = 6'h27;
  localparam functT FnSlt = 6'h2A;
  localparam functT FnSltu = 6'h2B;

  localparam aluOpT AluAdd = 4'd0;
  localparam aluOpT AluSub = 4'd1;
  localparam aluOpT AluAnd = 4'd2;
  localparam aluOpT AluOr = 4'd3;
  localparam aluOpT AluXor = 4'd4;
  localparam aluOpT AluNor = 4'd5;
  localparam aluOpT AluSlt = 4'd6;
  localparam aluOpT AluSltu = 4'd7;
  localparam aluOpT AluSll = 4'd8;
  localparam aluOpT AluSrl = 4'd9;
  localparam aluOpT AluSra = 4'd10;
  localparam aluOpT AluLui = 4'd11;

  // Opcode classes, relying on the MIPS numbering
  function automatic logic isImmAlu(opcodeT op);
    return (op >= OpAddiu) && (op <= OpLui);
  endfunction

  function automatic logic isLoad(opcodeT op);
    return (op >= OpLb) && (op <= OpLhu);
  endfunction

  function automatic logic isStore(opcodeT op);
    return (op >= OpSb) && (op <= OpSw);
  endfunction

endpackage
